// ==== cpu65.f ====
+incdir+.
cpu65_pkg.sv
stage_reg.sv
op_decoder.sv
exec_unit.sv
cpu65_core.sv
tb_cpu65.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu65
FILELIST  ?= cpu65.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] ref_a;
logic [7:0] ref_x;
logic [7:0] ref_y;
logic [7:0] ref_p;

task automatic reset_model();
    ref_a = 8'h00;
    ref_x = 8'h00;
    ref_y = 8'h00;
    ref_p = cpu65_pkg::P_RESET;
endtask

task automatic update_nz(input logic [7:0] v);
    ref_p[cpu65_pkg::P_N] = v[7];
    ref_p[cpu65_pkg::P_Z] = (v == 8'h00);
endtask

// Binary add with carry in, SBC passes M inverted
task automatic add_with_carry(input logic [7:0] m);
    int         total;
    logic [7:0] r;
    total = int'(ref_a) + int'(m) + int'(ref_p[cpu65_pkg::P_C]);
    r = total[7:0];
    ref_p[cpu65_pkg::P_C] = (total > 255);
    ref_p[cpu65_pkg::P_V] = (ref_a[7] == m[7]) && (r[7] != ref_a[7]);
    ref_a = r;
    update_nz(r);
endtask

task automatic compare_reg(input logic [7:0] r, input logic [7:0] m);
    logic [7:0] d;
    d = r - m;
    ref_p[cpu65_pkg::P_C] = (r >= m);           // Unsigned, no borrow
    update_nz(d);
endtask

task automatic load_reg(inout logic [7:0] r, input logic [7:0] v);
    r = v;
    update_nz(v);
endtask

task automatic apply_insn(input logic [7:0] opc, input logic [7:0] m, output logic ill);
    logic c_in;
    c_in = ref_p[cpu65_pkg::P_C];
    ill  = 1'b0;
    case (opc)
        8'h69: add_with_carry(m);
        8'hE9: add_with_carry(~m);
        8'h29: load_reg(ref_a, ref_a & m);
        8'h09: load_reg(ref_a, ref_a | m);
        8'h49: load_reg(ref_a, ref_a ^ m);
        8'hC9: compare_reg(ref_a, m);
        8'hE0: compare_reg(ref_x, m);
        8'hC0: compare_reg(ref_y, m);
        8'hA9: load_reg(ref_a, m);
        8'hA2: load_reg(ref_x, m);
        8'hA0: load_reg(ref_y, m);
        8'h89: ref_p[cpu65_pkg::P_Z] = ((ref_a & m) == 8'h00);  // Z only
        8'h0A: begin
            ref_p[cpu65_pkg::P_C] = ref_a[7];
            load_reg(ref_a, {ref_a[6:0], 1'b0});
        end
        8'h4A: begin
            ref_p[cpu65_pkg::P_C] = ref_a[0];
            load_reg(ref_a, {1'b0, ref_a[7:1]});
        end
        8'h2A: begin
            ref_p[cpu65_pkg::P_C] = ref_a[7];
            load_reg(ref_a, {ref_a[6:0], c_in});
        end
        8'h6A: begin
            ref_p[cpu65_pkg::P_C] = ref_a[0];
            load_reg(ref_a, {c_in, ref_a[7:1]});
        end
        8'h1A: load_reg(ref_a, ref_a + 8'd1);
        8'h3A: load_reg(ref_a, ref_a - 8'd1);
        8'hE8: load_reg(ref_x, ref_x + 8'd1);
        8'hC8: load_reg(ref_y, ref_y + 8'd1);
        8'hCA: load_reg(ref_x, ref_x - 8'd1);
        8'h88: load_reg(ref_y, ref_y - 8'd1);
        8'hAA: load_reg(ref_x, ref_a);
        8'hA8: load_reg(ref_y, ref_a);
        8'h8A: load_reg(ref_a, ref_x);
        8'h98: load_reg(ref_a, ref_y);
        8'h18: ref_p[cpu65_pkg::P_C] = 1'b0;
        8'h38: ref_p[cpu65_pkg::P_C] = 1'b1;
        8'hB8: ref_p[cpu65_pkg::P_V] = 1'b0;
        8'hEA: begin
        end
        default: ill = 1'b1;                    // State untouched
    endcase
endtask

`endif

// ==== tb_cpu65.sv ====
`timescale 1ns/1ns

module tb_cpu65;

    localparam int NUM_INSN    = 2000;
    localparam int CYCLE_LIMIT = 8 * NUM_INSN + 200;

    logic       i_clk;
    logic       i_rst;
    logic       in_valid;
    logic       in_ready;
    logic [7:0] in_opcode;
    logic [7:0] in_operand;
    logic       out_valid;
    logic       out_ready;
    logic [7:0] out_a;
    logic [7:0] out_x;
    logic [7:0] out_y;
    logic [7:0] out_p;
    logic       out_illegal;

    int          seed;
    int          cycles = 0;
    int          accepted;
    int          retired;
    logic        in_fire;
    logic        out_fire;
    logic        hold_pending;
    logic        ill;
    logic [4:0]  idx;
    logic [32:0] held_rec;
    logic [32:0] exp_rec;
    logic [32:0] exp_q[$];                      // {illegal, A, X, Y, P}

    logic [7:0] kept_ops [30] = '{
        8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9, 8'hE0, 8'hC0, 8'hA9, 8'hA2,
        8'hA0, 8'h89, 8'h0A, 8'h4A, 8'h2A, 8'h6A, 8'h1A, 8'h3A, 8'hE8, 8'hC8,
        8'hCA, 8'h88, 8'hAA, 8'hA8, 8'h8A, 8'h98, 8'h18, 8'h38, 8'hB8, 8'hEA
    };

    `include "tb_model.svh"

    cpu65_core #(
        .REG_W(8)
    ) DUT (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_opcode  (in_opcode),
        .in_operand (in_operand),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_a      (out_a),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_p      (out_p),
        .out_illegal(out_illegal)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d retired",
                     cycles, retired, NUM_INSN);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped");
        end
    endtask

    function automatic logic [32:0] current_record();
        return {out_illegal, out_a, out_x, out_y, out_p};
    endfunction

    task automatic compare_record(input string tag, input logic [32:0] exp);
        check_value({tag, "out_illegal"}, 32'(out_illegal), 32'(exp[32]));
        check_value({tag, "out_a"}, 32'(out_a), 32'(exp[31:24]));
        check_value({tag, "out_x"}, 32'(out_x), 32'(exp[23:16]));
        check_value({tag, "out_y"}, 32'(out_y), 32'(exp[15:8]));
        check_value({tag, "out_p"}, 32'(out_p), 32'(exp[7:0]));
    endtask

    function automatic logic chance(input int pct);
        int r;
        r = int'($unsigned($random(seed)) % 100);
        return r < pct;
    endfunction

    task automatic pick_instruction();
        if (chance(90)) begin
            idx       = 5'($unsigned($random(seed)) % 30);
            in_opcode = kept_ops[idx];
        end else begin
            in_opcode = 8'($random(seed));      // Mostly illegal bytes
        end
        in_operand = 8'($random(seed));
    endtask

    initial begin
        seed         = 25498;
        i_clk        = 1'b0;
        i_rst        = 1'b1;
        in_valid     = 1'b0;
        in_opcode    = 8'h00;
        in_operand   = 8'h00;
        out_ready    = 1'b0;
        accepted     = 0;
        retired      = 0;
        hold_pending = 1'b0;
        reset_model();
        repeat (4) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        // Idle state straight out of reset
        @(negedge i_clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'd1);
        compare_record("reset ", {1'b0, 8'h00, 8'h00, 8'h00, 8'h34});

        while (retired < NUM_INSN) begin
            @(negedge i_clk);
            if (hold_pending) begin
                check_value("held out_valid", 32'(out_valid), 32'd1);
                compare_record("held ", held_rec);
            end
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            if (out_fire) begin
                if (exp_q.size() == 0) begin
                    $display("record retired with no instruction outstanding");
                    $display("RESULT: FAIL");
                    $fatal(1, "simulation stopped");
                end else begin
                    exp_rec = exp_q.pop_front();
                    compare_record("", exp_rec);
                    retired = retired + 1;
                end
            end
            hold_pending = out_valid && !out_ready;
            held_rec     = current_record();

            @(posedge i_clk);
            #1;
            if (in_fire) begin
                apply_insn(in_opcode, in_operand, ill);
                exp_q.push_back({ill, ref_a, ref_x, ref_y, ref_p});
                accepted = accepted + 1;
            end
            if (!in_valid || in_fire) begin   // Hold an offer until taken
                in_valid = (accepted < NUM_INSN) && chance(70);
                pick_instruction();
            end
            out_ready = chance(70);
        end

        @(posedge i_clk);
        @(negedge i_clk);
        check_value("drained out_valid", 32'(out_valid), 32'd0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== cpu65_core.sv ====
`timescale 1ns/1ns

module cpu65_core #(
    parameter int REG_W = 8
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [7:0]       in_opcode,
    input  logic [REG_W-1:0] in_operand,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [REG_W-1:0] out_a,
    output logic [REG_W-1:0] out_x,
    output logic [REG_W-1:0] out_y,
    output logic [7:0]       out_p,
    output logic             out_illegal
);

    logic                     dec_valid;
    cpu65_pkg::decoded_insn_t dec_insn;
    logic                     exec_ready;
    logic [REG_W-1:0]         opnd_data;

    op_decoder u_decoder (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_opcode(in_opcode),
        .dec_valid(dec_valid),
        .dec_ready(exec_ready),
        .dec_insn (dec_insn)
    );

    // Operand travels beside the decoded opcode
    stage_reg #(
        .payload_t(logic [REG_W-1:0])
    ) u_opnd_stage (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .up_valid(in_valid),
        .up_ready(),
        .up_data (in_operand),
        .dn_valid(),
        .dn_ready(exec_ready),
        .dn_data (opnd_data)
    );

    exec_unit #(
        .REG_W(REG_W)
    ) u_exec (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .dec_valid  (dec_valid),
        .dec_insn   (dec_insn),
        .operand    (opnd_data),
        .exec_ready (exec_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_a      (out_a),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_p      (out_p),
        .out_illegal(out_illegal)
    );

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit #(
    parameter int REG_W = 8
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     dec_valid,
    input  cpu65_pkg::decoded_insn_t dec_insn,
    input  logic [REG_W-1:0]         operand,
    output logic                     exec_ready,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [REG_W-1:0]         out_a,
    output logic [REG_W-1:0]         out_x,
    output logic [REG_W-1:0]         out_y,
    output logic [7:0]               out_p,
    output logic                     out_illegal
);

    localparam logic [REG_W-1:0] ONE = REG_W'(1);

    logic [REG_W-1:0] a_q, x_q, y_q;
    logic [7:0]       p_q;
    logic [REG_W-1:0] a_n, x_n, y_n;
    logic [7:0]       p_n;
    logic [REG_W-1:0] m_val;          // M, or A in accumulator mode
    logic [REG_W-1:0] addend;
    logic [REG_W-1:0] cmp_src;
    logic [REG_W:0]   sum;
    logic [REG_W:0]   diff;
    logic [REG_W-1:0] res;            // Source of N and Z
    logic             set_nz;
    logic             consume;

    assign exec_ready = !out_valid || out_ready;
    assign consume    = dec_valid && exec_ready;

    assign m_val  = (dec_insn.addr_mode == cpu65_pkg::AM_ACC) ? a_q : operand;
    assign addend = (dec_insn.operation == cpu65_pkg::OP_SBC) ? ~m_val : m_val;
    assign sum    = {1'b0, a_q} + {1'b0, addend} + {{REG_W{1'b0}}, p_q[cpu65_pkg::P_C]};

    assign cmp_src = (dec_insn.operation == cpu65_pkg::OP_CPX) ? x_q :
                     (dec_insn.operation == cpu65_pkg::OP_CPY) ? y_q : a_q;
    assign diff    = {1'b0, cmp_src} - {1'b0, m_val};

    // ALU and flag rules
    always_comb begin
        a_n    = a_q;
        x_n    = x_q;
        y_n    = y_q;
        p_n    = p_q;
        res    = '0;
        set_nz = 1'b1;
        case (dec_insn.operation)
            cpu65_pkg::OP_ADC, cpu65_pkg::OP_SBC: begin
                a_n = sum[REG_W-1:0];
                p_n[cpu65_pkg::P_C] = sum[REG_W];
                p_n[cpu65_pkg::P_V] = (a_q[REG_W-1] == addend[REG_W-1]) &&
                                      (sum[REG_W-1] != a_q[REG_W-1]);
                res = a_n;
            end
            cpu65_pkg::OP_CMP, cpu65_pkg::OP_CPX, cpu65_pkg::OP_CPY: begin
                p_n[cpu65_pkg::P_C] = !diff[REG_W];   // No borrow
                res = diff[REG_W-1:0];
            end
            cpu65_pkg::OP_AND: begin
                a_n = a_q & m_val;
                res = a_n;
            end
            cpu65_pkg::OP_ORA: begin
                a_n = a_q | m_val;
                res = a_n;
            end
            cpu65_pkg::OP_EOR: begin
                a_n = a_q ^ m_val;
                res = a_n;
            end
            cpu65_pkg::OP_LDA: begin
                a_n = m_val;
                res = m_val;
            end
            cpu65_pkg::OP_LDX: begin
                x_n = m_val;
                res = m_val;
            end
            cpu65_pkg::OP_LDY: begin
                y_n = m_val;
                res = m_val;
            end
            cpu65_pkg::OP_BIT: begin
                set_nz = 1'b0;                        // Immediate form only touches Z
                p_n[cpu65_pkg::P_Z] = ~|(a_q & m_val);
            end
            cpu65_pkg::OP_ASL: begin
                p_n[cpu65_pkg::P_C] = m_val[REG_W-1];
                a_n = {m_val[REG_W-2:0], 1'b0};
                res = a_n;
            end
            cpu65_pkg::OP_LSR: begin
                p_n[cpu65_pkg::P_C] = m_val[0];
                a_n = {1'b0, m_val[REG_W-1:1]};
                res = a_n;
            end
            cpu65_pkg::OP_ROL: begin
                p_n[cpu65_pkg::P_C] = m_val[REG_W-1];
                a_n = {m_val[REG_W-2:0], p_q[cpu65_pkg::P_C]};
                res = a_n;
            end
            cpu65_pkg::OP_ROR: begin
                p_n[cpu65_pkg::P_C] = m_val[0];
                a_n = {p_q[cpu65_pkg::P_C], m_val[REG_W-1:1]};
                res = a_n;
            end
            cpu65_pkg::OP_INC: begin
                a_n = m_val + ONE;
                res = a_n;
            end
            cpu65_pkg::OP_DEC: begin
                a_n = m_val - ONE;
                res = a_n;
            end
            cpu65_pkg::OP_INX: begin
                x_n = x_q + ONE;
                res = x_n;
            end
            cpu65_pkg::OP_INY: begin
                y_n = y_q + ONE;
                res = y_n;
            end
            cpu65_pkg::OP_DEX: begin
                x_n = x_q - ONE;
                res = x_n;
            end
            cpu65_pkg::OP_DEY: begin
                y_n = y_q - ONE;
                res = y_n;
            end
            cpu65_pkg::OP_TAX: begin
                x_n = a_q;
                res = a_q;
            end
            cpu65_pkg::OP_TAY: begin
                y_n = a_q;
                res = a_q;
            end
            cpu65_pkg::OP_TXA: begin
                a_n = x_q;
                res = x_q;
            end
            cpu65_pkg::OP_TYA: begin
                a_n = y_q;
                res = y_q;
            end
            cpu65_pkg::OP_CLC: begin
                set_nz = 1'b0;
                p_n[cpu65_pkg::P_C] = 1'b0;
            end
            cpu65_pkg::OP_SEC: begin
                set_nz = 1'b0;
                p_n[cpu65_pkg::P_C] = 1'b1;
            end
            cpu65_pkg::OP_CLV: begin
                set_nz = 1'b0;
                p_n[cpu65_pkg::P_V] = 1'b0;
            end
            default: set_nz = 1'b0;                   // NOP and illegal
        endcase
        if (set_nz) begin
            p_n[cpu65_pkg::P_N] = res[REG_W-1];
            p_n[cpu65_pkg::P_Z] = (res == '0);
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
            a_q         <= '0;
            x_q         <= '0;
            y_q         <= '0;
            p_q         <= cpu65_pkg::P_RESET;
        end else begin
            if (exec_ready) begin
                out_valid <= dec_valid;
            end
            if (consume) begin
                out_illegal <= dec_insn.illegal;
                a_q         <= a_n;
                x_q         <= x_n;
                y_q         <= y_n;
                p_q         <= p_n;
            end
        end
    end

    // Record is the architectural state itself
    assign out_a = a_q;
    assign out_x = x_q;
    assign out_y = y_q;
    assign out_p = p_q;

    a_record_hold: assert property (
        @(posedge i_clk) disable iff (i_rst)
        out_valid && !out_ready |=>
            out_valid && $stable({out_a, out_x, out_y, out_p, out_illegal})
    );

    a_ub_set: assert property (
        @(posedge i_clk) disable iff (i_rst)
        out_p[cpu65_pkg::P_U] && out_p[cpu65_pkg::P_B]
    );

endmodule

// ==== op_decoder.sv ====
`timescale 1ns/1ns

module op_decoder (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [7:0]               in_opcode,
    output logic                     dec_valid,
    input  logic                     dec_ready,
    output cpu65_pkg::decoded_insn_t dec_insn
);

    cpu65_pkg::operation_t    op;
    cpu65_pkg::addr_mode_t    mode;
    logic                     illegal;
    cpu65_pkg::decoded_insn_t dec_next;

    // Opcode table
    always_comb begin
        op      = cpu65_pkg::OP_NOP;
        illegal = 1'b0;
        case (in_opcode)
            8'h69: op = cpu65_pkg::OP_ADC;
            8'hE9: op = cpu65_pkg::OP_SBC;
            8'h29: op = cpu65_pkg::OP_AND;
            8'h09: op = cpu65_pkg::OP_ORA;
            8'h49: op = cpu65_pkg::OP_EOR;
            8'hC9: op = cpu65_pkg::OP_CMP;
            8'hE0: op = cpu65_pkg::OP_CPX;
            8'hC0: op = cpu65_pkg::OP_CPY;
            8'hA9: op = cpu65_pkg::OP_LDA;
            8'hA2: op = cpu65_pkg::OP_LDX;
            8'hA0: op = cpu65_pkg::OP_LDY;
            8'h89: op = cpu65_pkg::OP_BIT;    // 65C02 BIT #
            8'h0A: op = cpu65_pkg::OP_ASL;
            8'h4A: op = cpu65_pkg::OP_LSR;
            8'h2A: op = cpu65_pkg::OP_ROL;
            8'h6A: op = cpu65_pkg::OP_ROR;
            8'h1A: op = cpu65_pkg::OP_INC;    // INC A
            8'h3A: op = cpu65_pkg::OP_DEC;    // DEC A
            8'hE8: op = cpu65_pkg::OP_INX;
            8'hC8: op = cpu65_pkg::OP_INY;
            8'hCA: op = cpu65_pkg::OP_DEX;
            8'h88: op = cpu65_pkg::OP_DEY;
            8'hAA: op = cpu65_pkg::OP_TAX;
            8'hA8: op = cpu65_pkg::OP_TAY;
            8'h8A: op = cpu65_pkg::OP_TXA;
            8'h98: op = cpu65_pkg::OP_TYA;
            8'h18: op = cpu65_pkg::OP_CLC;
            8'h38: op = cpu65_pkg::OP_SEC;
            8'hB8: op = cpu65_pkg::OP_CLV;
            8'hEA: op = cpu65_pkg::OP_NOP;
            default: illegal = 1'b1;          // Retires as NOP
        endcase
    end

    // Address mode follows from the operation
    always_comb begin
        case (op)
            cpu65_pkg::OP_ASL,
            cpu65_pkg::OP_LSR,
            cpu65_pkg::OP_ROL,
            cpu65_pkg::OP_ROR,
            cpu65_pkg::OP_INC,
            cpu65_pkg::OP_DEC: mode = cpu65_pkg::AM_ACC;
            cpu65_pkg::OP_ADC,
            cpu65_pkg::OP_SBC,
            cpu65_pkg::OP_AND,
            cpu65_pkg::OP_ORA,
            cpu65_pkg::OP_EOR,
            cpu65_pkg::OP_CMP,
            cpu65_pkg::OP_CPX,
            cpu65_pkg::OP_CPY,
            cpu65_pkg::OP_LDA,
            cpu65_pkg::OP_LDX,
            cpu65_pkg::OP_LDY,
            cpu65_pkg::OP_BIT: mode = cpu65_pkg::AM_IMM;
            default:           mode = cpu65_pkg::AM_IMP;
        endcase
    end

    assign dec_next = '{operation: op, addr_mode: mode, illegal: illegal};

    stage_reg #(
        .payload_t(cpu65_pkg::decoded_insn_t)
    ) u_dec_stage (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .up_valid(in_valid),
        .up_ready(in_ready),
        .up_data (dec_next),
        .dn_valid(dec_valid),
        .dn_ready(dec_ready),
        .dn_data (dec_insn)
    );

    a_illegal_is_nop: assert property (
        @(posedge i_clk) disable iff (i_rst)
        dec_valid && dec_insn.illegal |-> dec_insn.operation == cpu65_pkg::OP_NOP
    );

endmodule

// ==== stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     up_valid,
    output logic     up_ready,
    input  payload_t up_data,
    output logic     dn_valid,
    input  logic     dn_ready,
    output payload_t dn_data
);

    // Room when empty or the entry leaves this cycle
    assign up_ready = !dn_valid || dn_ready;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            dn_valid <= 1'b0;
        end else if (up_ready) begin
            dn_valid <= up_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (up_ready && up_valid) begin
            dn_data <= up_data;       // Payload only
        end
    end

    // Held entry must not change until taken
    a_hold_stable: assert property (
        @(posedge i_clk) disable iff (i_rst)
        dn_valid && !dn_ready |=> dn_valid && $stable(dn_data)
    );

endmodule

// ==== cpu65_pkg.sv ====
package cpu65_pkg;

    // Operations kept in this slice
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADC,
        OP_SBC,
        OP_AND,
        OP_ORA,
        OP_EOR,
        OP_CMP,
        OP_CPX,
        OP_CPY,
        OP_LDA,
        OP_LDX,
        OP_LDY,
        OP_BIT,
        OP_ASL,
        OP_LSR,
        OP_ROL,
        OP_ROR,
        OP_INC,
        OP_DEC,
        OP_INX,
        OP_INY,
        OP_DEX,
        OP_DEY,
        OP_TAX,
        OP_TAY,
        OP_TXA,
        OP_TYA,
        OP_CLC,
        OP_SEC,
        OP_CLV
    } operation_t;

    typedef enum logic [1:0] {
        AM_IMM,                       // Immediate #
        AM_ACC,                       // Accumulator A
        AM_IMP                        // Implied
    } addr_mode_t;

    typedef struct packed {
        operation_t operation;
        addr_mode_t addr_mode;
        logic       illegal;          // Opcode outside the kept set
    } decoded_insn_t;

    // Status register bit positions
    localparam int P_N = 7;           // Negative
    localparam int P_V = 6;           // Overflow
    localparam int P_U = 5;           // Unused, reads as one
    localparam int P_B = 4;           // Break
    localparam int P_D = 3;           // Decimal
    localparam int P_I = 2;           // IRQ disable
    localparam int P_Z = 1;           // Zero
    localparam int P_C = 0;           // Carry

    localparam logic [7:0] P_RESET = 8'h34;  // U, B and I set

endpackage
